/* include/vldu_consts.svh */
// Vector load unit constants
// Lane count, data widths, queue depths and field widths

`ifndef VLDU_CONSTS_SVH
`define VLDU_CONSTS_SVH

// Lane organisation
`define VLDU_NR_LANES      4
`define VLDU_ELEN          64

// Memory beat and register file word geometry, in bytes
`define VLDU_BEAT_BYTES    8
`define VLDU_WORD_BYTES    32
`define VLDU_VREG_WORDS    8

// Queue depths
`define VLDU_INSN_DEPTH    4
`define VLDU_RESULT_DEPTH  2

// Field widths, vl reaches 256
`define VLDU_ID_W          3
`define VLDU_VL_W          9
`define VLDU_VADDR_W       8

`endif

/* source/vldu_pkg.sv */
// Vector load unit types
// Instruction and packed result word formats shared by all stages

`default_nettype none

`include "vldu_consts.svh"

package vldu_pkg;

  // Vector register number, whatever of the word address is left above the word index
  localparam int unsigned VregW = `VLDU_VADDR_W - $clog2(`VLDU_VREG_WORDS);

  typedef logic [`VLDU_ID_W-1:0]        vid_t;
  typedef logic [`VLDU_VADDR_W-1:0]     vaddr_t;
  typedef logic [VregW-1:0]             vreg_t;
  typedef logic [`VLDU_VL_W-1:0]        vlen_t;
  typedef logic [`VLDU_ELEN-1:0]        elen_t;
  typedef logic [`VLDU_ELEN/8-1:0]      strb_t;

  // Element width, also the byte shift of vl
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  // One queued load
  typedef struct packed {
    vid_t  id;
    vreg_t vd;
    vlen_t vl;
    vsew_e vsew;
  } ldu_insn_t;

  // Data and byte enables headed for one lane
  typedef struct packed {
    elen_t wdata;
    strb_t be;
  } lane_slice_t;

  // One full register file word spread over the lanes
  typedef struct packed {
    vid_t                                id;
    vaddr_t                              addr;
    lane_slice_t [`VLDU_NR_LANES-1:0]    slices;
    logic                                last;
  } result_word_t;

endpackage

`default_nettype wire

/* source/vldu_fifo.sv */
// Circular show-ahead queue
// Head is readable without a pop; payload type is a parameter

`timescale 1ns/10ps
`default_nettype none

module vldu_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     head_o,
  output logic valid_o,
  output logic full_o
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  T              mem_q [DEPTH];
  logic [PtrW-1:0] rd_ptr_q, wr_ptr_q;
  logic [CntW-1:0] cnt_q, cnt_d;
  logic            full_q;
  logic            push_en, pop_en;

  // A push into a full queue only goes through alongside a pop
  assign pop_en  = pop_i && valid_o;
  assign push_en = push_i && (!full_q || pop_en);

  assign head_o  = mem_q[rd_ptr_q];
  assign valid_o = (cnt_q != '0);
  assign full_o  = full_q;

  always_comb begin
    cnt_d = cnt_q;
    if (push_en && !pop_en) begin
      cnt_d = cnt_q + CntW'(1);
    end else if (pop_en && !push_en) begin
      cnt_d = cnt_q - CntW'(1);
    end
  end

  // Pointers and count, full reads high while in reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
      full_q   <= 1'b1;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(DEPTH - 1)) ? '0 : wr_ptr_q + PtrW'(1);
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(DEPTH - 1)) ? '0 : rd_ptr_q + PtrW'(1);
      end
      cnt_q  <= cnt_d;
      full_q <= (cnt_d == CntW'(DEPTH));
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* source/vldu_beat_packer.sv */
// Beat packer of the vector load unit
// Writes full memory beats sequentially into lane slices of a register
// file word for the head instruction and pushes each finished word

`timescale 1ns/10ps
`default_nettype none

`include "vldu_consts.svh"

module vldu_beat_packer (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Head of the instruction queue
  input  vldu_pkg::ldu_insn_t            insn_i,
  input  logic                           insn_valid_i,
  output logic                           insn_pop_o,
  // Memory read beats
  input  logic                           beat_valid_i,
  input  logic [`VLDU_BEAT_BYTES*8-1:0]  beat_data_i,
  output logic                           beat_ready_o,
  // Result queue
  input  logic                           result_full_i,
  output logic                           result_push_o,
  output vldu_pkg::result_word_t         result_o
);

  // vl shifted by the largest vsew
  localparam int unsigned BytesW  = `VLDU_VL_W + 3;
  localparam int unsigned OffsetW = $clog2(`VLDU_WORD_BYTES);
  localparam int unsigned LaneLsb = $clog2(`VLDU_BEAT_BYTES);
  localparam int unsigned LaneW   = $clog2(`VLDU_NR_LANES);

  ////////////////////////////////////////////////////////////////////////
  // Byte accounting
  ////////////////////////////////////////////////////////////////////////

  // Bytes of the head instruction already handed to words
  logic [BytesW-1:0]  issued_q;
  logic [BytesW-1:0]  issued_next;
  logic [BytesW-1:0]  bytes_total;
  logic [LaneW-1:0]   cur_lane;
  logic               insn_last;
  logic               word_done;
  logic               beat_fire;
  vldu_pkg::vaddr_t   word_addr;

  // Total bytes of the instruction
  assign bytes_total = BytesW'(insn_i.vl) << insn_i.vsew;
  assign issued_next = issued_q + BytesW'(`VLDU_BEAT_BYTES);

  // Beats are aligned, so a beat lands on exactly one lane slice
  assign cur_lane    = issued_q[LaneLsb +: LaneW];

  // This beat runs the instruction out of bytes
  assign insn_last   = (issued_next >= bytes_total);
  // This beat fills the word, or ends the instruction early
  assign word_done   = insn_last || (issued_next[OffsetW-1:0] == '0);

  // Word address, vd base plus word index within the instruction
  assign word_addr   = vldu_pkg::vaddr_t'(
                         {insn_i.vd, {$clog2(`VLDU_VREG_WORDS){1'b0}}}
                         + (issued_q >> OffsetW));

  ////////////////////////////////////////////////////////////////////////
  // Beat handshake
  ////////////////////////////////////////////////////////////////////////

  // Stall only the beat that would push into a full result queue
  assign beat_ready_o  = insn_valid_i && !(word_done && result_full_i);
  assign beat_fire     = beat_valid_i && beat_ready_o;

  assign result_push_o = beat_fire && word_done;
  assign insn_pop_o    = beat_fire && insn_last;

  ////////////////////////////////////////////////////////////////////////
  // Word assembly
  ////////////////////////////////////////////////////////////////////////

  vldu_pkg::lane_slice_t                     beat_slice;
  vldu_pkg::lane_slice_t [`VLDU_NR_LANES-1:0] slices_q;

  // Beat as a lane slice; bytes beyond vl get no enable
  always_comb begin
    beat_slice.wdata = beat_data_i;
    for (int b = 0; b < `VLDU_BEAT_BYTES; b++) begin
      beat_slice.be[b] = ((issued_q + BytesW'(b)) < bytes_total);
    end
  end

  // Lanes below the current one come from storage, the current one
  // straight from the beat, lanes above stay empty
  always_comb begin
    result_o.id   = insn_i.id;
    result_o.addr = word_addr;
    result_o.last = insn_last;
    for (int l = 0; l < `VLDU_NR_LANES; l++) begin
      if (LaneW'(l) < cur_lane) begin
        result_o.slices[l] = slices_q[l];
      end else if (LaneW'(l) == cur_lane) begin
        result_o.slices[l] = beat_slice;
      end else begin
        result_o.slices[l] = '0;
      end
    end
  end

  // Byte counter restarts with the next instruction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q <= '0;
    end else if (beat_fire) begin
      issued_q <= insn_last ? '0 : issued_next;
    end
  end

  // Partial word under assembly
  always_ff @(posedge clk_i) begin
    if (beat_fire) begin
      slices_q[cur_lane] <= beat_slice;
    end
  end

endmodule

`default_nettype wire

/* source/vldu_lane_writer.sv */
// Lane writer of the vector load unit
// Offers the head result word to every lane, tracks per-lane grants,
// pops once all lanes took their slice and reports load completion

`timescale 1ns/10ps
`default_nettype none

`include "vldu_consts.svh"

module vldu_lane_writer (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // Result queue head
  input  vldu_pkg::result_word_t                    head_i,
  input  logic                                      head_valid_i,
  output logic                                      pop_o,
  // Lanes
  output logic              [`VLDU_NR_LANES-1:0]    ldu_result_req_o,
  output vldu_pkg::vid_t    [`VLDU_NR_LANES-1:0]    ldu_result_id_o,
  output vldu_pkg::vaddr_t  [`VLDU_NR_LANES-1:0]    ldu_result_addr_o,
  output vldu_pkg::elen_t   [`VLDU_NR_LANES-1:0]    ldu_result_wdata_o,
  output vldu_pkg::strb_t   [`VLDU_NR_LANES-1:0]    ldu_result_be_o,
  input  logic              [`VLDU_NR_LANES-1:0]    ldu_result_gnt_i,
  // Completion
  output logic                                      load_complete_o,
  output vldu_pkg::vid_t                            done_id_o
);

  // Lanes that already took the head word
  logic [`VLDU_NR_LANES-1:0] granted_q;
  logic [`VLDU_NR_LANES-1:0] gnt_fire;
  logic                      all_granted;
  logic                      complete_q;
  vldu_pkg::vid_t            done_id_q;

  // Every lane sees the same head word, its own slice of data
  always_comb begin
    for (int l = 0; l < `VLDU_NR_LANES; l++) begin
      ldu_result_req_o[l]   = head_valid_i && !granted_q[l];
      ldu_result_id_o[l]    = head_i.id;
      ldu_result_addr_o[l]  = head_i.addr;
      ldu_result_wdata_o[l] = head_i.slices[l].wdata;
      ldu_result_be_o[l]    = head_i.slices[l].be;
    end
  end

  assign gnt_fire    = ldu_result_req_o & ldu_result_gnt_i;
  assign all_granted = &(granted_q | gnt_fire);

  // A last word waits one cycle behind a completion pulse,
  // so each pulse stands alone
  assign pop_o = head_valid_i && all_granted && !(head_i.last && complete_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      granted_q  <= '0;
      complete_q <= 1'b0;
    end else begin
      granted_q  <= pop_o ? '0 : (granted_q | gnt_fire);
      complete_q <= pop_o && head_i.last;
    end
  end

  // Id of the instruction whose final word just left
  always_ff @(posedge clk_i) begin
    if (pop_o && head_i.last) begin
      done_id_q <= head_i.id;
    end
  end

  assign load_complete_o = complete_q;
  assign done_id_o       = done_id_q;

endmodule

`default_nettype wire

/* source/vldu_top.sv */
// Vector load unit top level
// Instruction queue, beat packer, result queue and lane writer in a chain

`timescale 1ns/10ps
`default_nettype none

`include "vldu_consts.svh"

module vldu_top (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // Sequencer
  input  logic                                      insn_valid_i,
  input  vldu_pkg::vid_t                            insn_id_i,
  input  vldu_pkg::vreg_t                           insn_vd_i,
  input  vldu_pkg::vlen_t                           insn_vl_i,
  input  vldu_pkg::vsew_e                           insn_vsew_i,
  output logic                                      insn_ready_o,
  // Memory read beats
  input  logic                                      beat_valid_i,
  input  logic              [`VLDU_BEAT_BYTES*8-1:0] beat_data_i,
  output logic                                      beat_ready_o,
  // Lanes
  output logic              [`VLDU_NR_LANES-1:0]    ldu_result_req_o,
  output vldu_pkg::vid_t    [`VLDU_NR_LANES-1:0]    ldu_result_id_o,
  output vldu_pkg::vaddr_t  [`VLDU_NR_LANES-1:0]    ldu_result_addr_o,
  output vldu_pkg::elen_t   [`VLDU_NR_LANES-1:0]    ldu_result_wdata_o,
  output vldu_pkg::strb_t   [`VLDU_NR_LANES-1:0]    ldu_result_be_o,
  input  logic              [`VLDU_NR_LANES-1:0]    ldu_result_gnt_i,
  // Completion
  output logic                                      load_complete_o,
  output vldu_pkg::vid_t                            done_id_o
);

  ////////////////////////////////////////////////////////////////////////
  // Instruction queue
  ////////////////////////////////////////////////////////////////////////

  vldu_pkg::ldu_insn_t    insn_in, insn_head;
  logic                   insn_full, insn_head_valid, insn_pop;

  assign insn_in = '{id: insn_id_i, vd: insn_vd_i, vl: insn_vl_i, vsew: insn_vsew_i};
  assign insn_ready_o = !insn_full;

  vldu_fifo #(
    .T     (vldu_pkg::ldu_insn_t),
    .DEPTH (`VLDU_INSN_DEPTH)
  ) i_insn_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (insn_valid_i && insn_ready_o),
    .data_i  (insn_in),
    .pop_i   (insn_pop),
    .head_o  (insn_head),
    .valid_o (insn_head_valid),
    .full_o  (insn_full)
  );

  ////////////////////////////////////////////////////////////////////////
  // Packing and result queue
  ////////////////////////////////////////////////////////////////////////

  vldu_pkg::result_word_t res_word, res_head;
  logic                   res_push, res_full, res_head_valid, res_pop;

  vldu_beat_packer i_packer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn_head),
    .insn_valid_i  (insn_head_valid),
    .insn_pop_o    (insn_pop),
    .beat_valid_i  (beat_valid_i),
    .beat_data_i   (beat_data_i),
    .beat_ready_o  (beat_ready_o),
    .result_full_i (res_full),
    .result_push_o (res_push),
    .result_o      (res_word)
  );

  vldu_fifo #(
    .T     (vldu_pkg::result_word_t),
    .DEPTH (`VLDU_RESULT_DEPTH)
  ) i_result_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (res_push),
    .data_i  (res_word),
    .pop_i   (res_pop),
    .head_o  (res_head),
    .valid_o (res_head_valid),
    .full_o  (res_full)
  );

  // Lane interface and completion
  vldu_lane_writer i_lane_writer (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .head_i             (res_head),
    .head_valid_i       (res_head_valid),
    .pop_o              (res_pop),
    .ldu_result_req_o   (ldu_result_req_o),
    .ldu_result_id_o    (ldu_result_id_o),
    .ldu_result_addr_o  (ldu_result_addr_o),
    .ldu_result_wdata_o (ldu_result_wdata_o),
    .ldu_result_be_o    (ldu_result_be_o),
    .ldu_result_gnt_i   (ldu_result_gnt_i),
    .load_complete_o    (load_complete_o),
    .done_id_o          (done_id_o)
  );

endmodule

`default_nettype wire

/* sim/vldu_props.sv */
// Lane writer properties
// Request hold until grant, single-cycle completion pulse and pop legality

`timescale 1ns/10ps
`default_nettype none

`include "vldu_consts.svh"

module vldu_props (
  input logic                                     clk_i,
  input logic                                     rst_ni,
  input logic                                     head_valid_i,
  input logic                                     pop_i,
  input logic             [`VLDU_NR_LANES-1:0]    req_i,
  input logic             [`VLDU_NR_LANES-1:0]    gnt_i,
  input vldu_pkg::vid_t   [`VLDU_NR_LANES-1:0]    id_i,
  input vldu_pkg::vaddr_t [`VLDU_NR_LANES-1:0]    addr_i,
  input vldu_pkg::elen_t  [`VLDU_NR_LANES-1:0]    wdata_i,
  input vldu_pkg::strb_t  [`VLDU_NR_LANES-1:0]    be_i,
  input logic                                     complete_i
);

  // An ungranted request holds, with the same word, into the next cycle
  for (genvar l = 0; l < `VLDU_NR_LANES; l++) begin : g_lane
    req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      req_i[l] && !gnt_i[l] |=> req_i[l] && $stable(id_i[l]) && $stable(addr_i[l])
        && $stable(wdata_i[l]) && $stable(be_i[l]))
      else $error("lane %0d dropped its request or changed data before the grant", l);
  end

  // Completion is a single-cycle pulse
  complete_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    complete_i |=> !complete_i)
    else $error("load_complete_o high in two consecutive cycles");

  // A pop needs a valid head and no lane still waiting for its grant
  pop_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> head_valid_i && ((req_i & ~gnt_i) == '0))
    else $error("lane writer popped without a valid head or before every lane was granted");

endmodule

bind vldu_lane_writer vldu_props i_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .head_valid_i (head_valid_i),
  .pop_i        (pop_o),
  .req_i        (ldu_result_req_o),
  .gnt_i        (ldu_result_gnt_i),
  .id_i         (ldu_result_id_o),
  .addr_i       (ldu_result_addr_o),
  .wdata_i      (ldu_result_wdata_o),
  .be_i         (ldu_result_be_o),
  .complete_i   (load_complete_o)
);

`default_nettype wire

/* sim/vldu_tb.sv */
// Vector load unit testbench
// Streams loads and memory beats from a case file, models the lanes with
// random grants and checks every lane word and every completion

`timescale 1ns/10ps
`default_nettype none

`include "vldu_consts.svh"

module vldu_tb;

  localparam int NR        = `VLDU_NR_LANES;
  localparam int BB        = `VLDU_BEAT_BYTES;
  localparam int WB        = `VLDU_WORD_BYTES;
  localparam int MAX_CASES = 32;
  // Cycles a stall case keeps its grants off
  localparam int HOLD      = 40;
  localparam int LIMIT     = 5000;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          insn_valid_i;
  logic                          insn_ready_o;
  vldu_pkg::vid_t                insn_id_i;
  vldu_pkg::vreg_t               insn_vd_i;
  vldu_pkg::vlen_t               insn_vl_i;
  vldu_pkg::vsew_e               insn_vsew_i;
  logic                          beat_valid_i;
  logic [BB*8-1:0]               beat_data_i;
  logic                          beat_ready_o;
  logic [NR-1:0]                 ldu_result_req_o;
  logic [NR-1:0]                 ldu_result_gnt_i;
  vldu_pkg::vid_t   [NR-1:0]     ldu_result_id_o;
  vldu_pkg::vaddr_t [NR-1:0]     ldu_result_addr_o;
  vldu_pkg::elen_t  [NR-1:0]     ldu_result_wdata_o;
  vldu_pkg::strb_t  [NR-1:0]     ldu_result_be_o;
  logic                          load_complete_o;
  vldu_pkg::vid_t                done_id_o;

  // Case table and the expected word stream in lane order
  logic [11:0] case_mem [0:5*MAX_CASES-1];
  int          case_id [MAX_CASES];
  int          case_vd [MAX_CASES];
  int          case_vl [MAX_CASES];
  int          case_sew [MAX_CASES];
  int          case_prob [MAX_CASES];
  int          case_bytes [MAX_CASES];
  int          case_last_word [MAX_CASES];
  int          word_case [$];
  int          word_idx [$];
  int          n_cases, n_words, done_ptr, hold_cnt;
  int          lane_ptr [NR];
  int          err_cnt, err_mark, tests_run, tests_failed;
  integer      seed;
  logic        timed_out, stall_seen;

  vldu_top DUT (.*);

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////
  // Expected data
  ////////////////////////////////////////////////////////////////////

  // Byte k of a load carries id*64 + k
  function automatic logic [7:0] pattern_byte(int id, int k);
    return 8'((id * 64 + k) % 256);
  endfunction

  function automatic logic [BB*8-1:0] beat_payload(int c, int j);
    logic [BB*8-1:0] d;
    for (int b = 0; b < BB; b++) begin
      d[b*8 +: 8] = pattern_byte(case_id[c], j * BB + b);
    end
    return d;
  endfunction

  // Byte k lands in word k/32, lane (k mod 32)/8, byte k mod 8
  function automatic logic [BB-1:0] expected_be(int c, int w, int l);
    logic [BB-1:0] be;
    for (int b = 0; b < BB; b++) begin
      be[b] = (w * WB + l * BB + b) < case_bytes[c];
    end
    return be;
  endfunction

  // Disabled bytes read as zero
  function automatic logic [BB*8-1:0] expected_data(int c, int w, int l);
    logic [BB*8-1:0] d;
    d = '0;
    for (int b = 0; b < BB; b++) begin
      if ((w * WB + l * BB + b) < case_bytes[c]) begin
        d[b*8 +: 8] = pattern_byte(case_id[c], w * WB + l * BB + b);
      end
    end
    return d;
  endfunction

  task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] got);
    $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, got);
    err_cnt++;
  endtask

  task automatic close_test(string label);
    tests_run++;
    if (err_cnt == err_mark) begin
      $display("Test %0d %s: passed", tests_run, label);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAILED with %0d errors", tests_run, label, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////

  task automatic drive_instructions();
    int cyc;
    for (int i = 0; i < n_cases; i++) begin
      @(posedge clk_i);
      insn_valid_i <= 1'b1;
      insn_id_i    <= vldu_pkg::vid_t'(case_id[i]);
      insn_vd_i    <= vldu_pkg::vreg_t'(case_vd[i]);
      insn_vl_i    <= vldu_pkg::vlen_t'(case_vl[i]);
      insn_vsew_i  <= vldu_pkg::vsew_e'(2'(case_sew[i]));
      cyc = 0;
      @(negedge clk_i);
      while (!insn_ready_o && cyc < LIMIT) begin
        @(negedge clk_i);
        cyc++;
      end
      if (!insn_ready_o) begin
        $display("Timeout: load %0d was never accepted", i);
        timed_out = 1'b1;
        return;
      end
    end
    @(posedge clk_i);
    insn_valid_i <= 1'b0;
  endtask

  // Transfer happens on the edge after ready is seen, next beat goes out on it
  task automatic drive_beats();
    int cyc;
    for (int c = 0; c < n_cases; c++) begin
      for (int j = 0; j < (case_bytes[c] + BB - 1) / BB; j++) begin
        @(posedge clk_i);
        beat_valid_i <= 1'b1;
        beat_data_i  <= beat_payload(c, j);
        cyc = 0;
        @(negedge clk_i);
        while (!beat_ready_o && cyc < LIMIT) begin
          @(negedge clk_i);
          cyc++;
        end
        if (!beat_ready_o) begin
          $display("Timeout: beat %0d of load %0d was never accepted", j, c);
          timed_out = 1'b1;
          return;
        end
      end
    end
    @(posedge clk_i);
    beat_valid_i <= 1'b0;
  endtask

  // Lane model, probability taken from the word each lane waits for
  always @(posedge clk_i) begin : lane_grants
    int prob;
    int rnd;
    for (int l = 0; l < NR; l++) begin
      prob = 100;
      if (lane_ptr[l] < n_words) begin
        prob = case_prob[word_case[lane_ptr[l]]];
      end
      rnd = $random(seed);
      if (!rst_ni) begin
        ldu_result_gnt_i[l] <= 1'b0;
      end else if (prob == 0) begin
        ldu_result_gnt_i[l] <= (hold_cnt >= HOLD);
      end else begin
        ldu_result_gnt_i[l] <= int'($unsigned(rnd) % 32'd100) < prob;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Lane and completion checks
  ////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : monitor
    int c;
    int w;
    logic [BB-1:0]   be;
    logic [BB*8-1:0] mask;
    logic            withhold;
    if (rst_ni) begin
      withhold = 1'b0;
      for (int l = 0; l < NR; l++) begin
        if (ldu_result_req_o[l] && lane_ptr[l] < n_words && hold_cnt < HOLD
            && case_prob[word_case[lane_ptr[l]]] == 0) begin
          withhold = 1'b1;
        end
      end
      // Stall case at the head, beats should back up
      if (withhold) begin
        hold_cnt++;
        if (beat_valid_i && !beat_ready_o) begin
          stall_seen = 1'b1;
        end
      end
      for (int l = 0; l < NR; l++) begin
        if (ldu_result_req_o[l] && ldu_result_gnt_i[l]) begin
          if (lane_ptr[l] >= n_words) begin
            $display("ERROR at %0t: lane %0d took a word beyond the last one", $time, l);
            err_cnt++;
          end else begin
            c  = word_case[lane_ptr[l]];
            w  = word_idx[lane_ptr[l]];
            be = expected_be(c, w, l);
            for (int b = 0; b < BB; b++) begin
              mask[b*8 +: 8] = {8{be[b]}};
            end
            if (ldu_result_id_o[l] != vldu_pkg::vid_t'(case_id[c])) begin
              report_mismatch($sformatf("ldu_result_id_o[%0d]", l),
                              64'(case_id[c]), 64'(ldu_result_id_o[l]));
            end
            if (ldu_result_addr_o[l] != 8'(case_vd[c] * `VLDU_VREG_WORDS + w)) begin
              report_mismatch($sformatf("ldu_result_addr_o[%0d]", l),
                              64'(8'(case_vd[c] * `VLDU_VREG_WORDS + w)),
                              64'(ldu_result_addr_o[l]));
            end
            if (ldu_result_be_o[l] != be) begin
              report_mismatch($sformatf("ldu_result_be_o[%0d]", l),
                              64'(be), 64'(ldu_result_be_o[l]));
            end
            if ((ldu_result_wdata_o[l] & mask) != expected_data(c, w, l)) begin
              report_mismatch($sformatf("ldu_result_wdata_o[%0d]", l),
                              expected_data(c, w, l), ldu_result_wdata_o[l] & mask);
            end
            lane_ptr[l]++;
          end
        end
      end
      if (load_complete_o) begin
        if (done_ptr >= n_cases) begin
          $display("ERROR at %0t: completion with no outstanding load", $time);
          err_cnt++;
        end else begin
          if (done_id_o != vldu_pkg::vid_t'(case_id[done_ptr])) begin
            report_mismatch("done_id_o", 64'(case_id[done_ptr]), 64'(done_id_o));
          end
          for (int l = 0; l < NR; l++) begin
            if (lane_ptr[l] <= case_last_word[done_ptr]) begin
              $display("ERROR at %0t: load %0d completed before lane %0d took its words",
                       $time, done_ptr, l);
              err_cnt++;
            end
          end
          if (case_prob[done_ptr] == 0) begin
            if (!stall_seen) begin
              $display("ERROR at %0t: beat_ready_o never dropped while grants were held",
                       $time);
              err_cnt++;
            end
            hold_cnt   = 0;
            stall_seen = 1'b0;
          end
          close_test($sformatf("load id %0d vl %0d sew %0d", case_id[done_ptr],
                               case_vl[done_ptr], 8 << case_sew[done_ptr]));
          done_ptr++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    int cyc;
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    insn_valid_i     = 1'b0;
    insn_id_i        = '0;
    insn_vd_i        = '0;
    insn_vl_i        = '0;
    insn_vsew_i      = vldu_pkg::EW8;
    beat_valid_i     = 1'b0;
    beat_data_i      = '0;
    ldu_result_gnt_i = '0;
    seed             = 93844;
    n_cases          = 0;
    done_ptr         = 0;
    hold_cnt         = 0;
    err_cnt          = 0;
    err_mark         = 0;
    tests_run        = 0;
    tests_failed     = 0;
    timed_out        = 1'b0;
    stall_seen       = 1'b0;
    for (int l = 0; l < NR; l++) begin
      lane_ptr[l] = 0;
    end
    for (int i = 0; i < 5 * MAX_CASES; i++) begin
      case_mem[i] = '0;
    end
    $readmemh("sim/vldu_cases.txt", case_mem);
    // A zero vl ends the table
    while (n_cases < MAX_CASES && case_mem[5*n_cases+2] != '0) begin
      case_id[n_cases]    = int'(case_mem[5*n_cases]);
      case_vd[n_cases]    = int'(case_mem[5*n_cases+1]);
      case_vl[n_cases]    = int'(case_mem[5*n_cases+2]);
      case_sew[n_cases]   = int'(case_mem[5*n_cases+3]);
      case_prob[n_cases]  = int'(case_mem[5*n_cases+4]);
      case_bytes[n_cases] = case_vl[n_cases] << case_sew[n_cases];
      for (int w = 0; w * WB < case_bytes[n_cases]; w++) begin
        word_case.push_back(n_cases);
        word_idx.push_back(w);
      end
      case_last_word[n_cases] = word_case.size() - 1;
      n_cases++;
    end
    n_words = word_case.size();

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (ldu_result_req_o != '0) begin
      report_mismatch("ldu_result_req_o", 64'd0, 64'(ldu_result_req_o));
    end
    if (beat_ready_o) begin
      report_mismatch("beat_ready_o", 64'd0, 64'd1);
    end
    if (load_complete_o) begin
      report_mismatch("load_complete_o", 64'd0, 64'd1);
    end
    cyc = 0;
    while (!insn_ready_o && cyc < 3) begin
      @(negedge clk_i);
      cyc++;
    end
    if (!insn_ready_o) begin
      $display("ERROR at %0t: insn_ready_o stayed low after reset", $time);
      err_cnt++;
    end
    close_test("reset state");

    fork
      drive_instructions();
      drive_beats();
    join_none
    cyc = 0;
    while (done_ptr < n_cases && !timed_out && cyc < 20 * LIMIT) begin
      @(negedge clk_i);
      cyc++;
    end
    if (done_ptr < n_cases && !timed_out) begin
      $display("Timeout: only %0d of %0d loads completed", done_ptr, n_cases);
      timed_out = 1'b1;
    end
    for (int l = 0; l < NR; l++) begin
      if (lane_ptr[l] != n_words) begin
        $display("ERROR: lane %0d took %0d of %0d words", l, lane_ptr[l], n_words);
        err_cnt++;
      end
    end
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/vldu_cases.txt */
// Load cases in hex, one per line: id vd vl vsew grant_percent
// A grant percentage of 0 holds all grants off for a while, then grants every cycle
1 02 020 0 64
2 05 00d 1 64
3 0a 028 0 64
4 01 015 2 64
5 11 040 0 32
6 03 040 3 4b
7 08 007 2 1e
0 1f 010 1 50
1 04 100 0 00
2 06 020 0 64
3 0c 003 0 0a
4 14 011 3 3c
5 09 080 1 19
6 00 001 3 64
7 1a 0c0 0 46
0 0e 02b 2 28

/* verilog.f */
+incdir+include
source/vldu_pkg.sv
source/vldu_fifo.sv
source/vldu_beat_packer.sv
source/vldu_lane_writer.sv
source/vldu_top.sv
sim/vldu_props.sv
sim/vldu_tb.sv

/* Makefile */
# Verilator simulation of the vector load unit

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module vldu_tb -f verilog.f
	./obj_dir/Vvldu_tb | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
